// File: Bender.yml
package:
  name: router_output

sources:
  - files:
      - design/routerPkg.sv
      - design/flitDecoder.sv
      - design/grantTimer.sv
      - design/portArbiter.sv
      - design/flitSwitch.sv
      - design/routerOutput.sv
  - target: test
    files:
      - bench/routerOutputTb.sv

// File: bench/routerOutputTb.sv
`default_nettype none

module routerOutputTb;

  localparam int resetCycles = 3;
  localparam int drainCycles = 2;
  localparam int testCount = 5;
  localparam int payloadWidth = routerPkg::flitWidth - routerPkg::flitIdWidth;

  typedef struct {
    int testId;
    logic [routerPkg::portCount-1:0] req;
    logic [routerPkg::portCount-1:0][routerPkg::flitWidth-1:0] flit;
  } stimRow;

  logic clk;
  logic rst;
  logic [routerPkg::portCount-1:0][routerPkg::flitWidth-1:0] flitIn;
  logic [routerPkg::portCount-1:0] req;
  logic [routerPkg::portCount-1:0] grant;
  logic [routerPkg::flitWidth-1:0] flitOut;
  logic flitOutValid;

  stimRow rows [$];
  string testName [1:testCount];
  int testErrors [1:testCount];
  logic [31:0] lfsr;
  int errCount;
  int checkCount;
  int cycleCount;
  int cycleLimit;

  // holder -1 means the reference model is idle.
  int mHolder;
  int mLimit [routerPkg::portCount];
  int mCount [routerPkg::portCount];
  logic [routerPkg::flitWidth-1:0] mFlitOut;
  logic mValidOut;
  logic [routerPkg::portCount-1:0] appliedReq;
  logic [routerPkg::portCount-1:0][routerPkg::flitWidth-1:0] appliedFlit;

  routerOutput dut0
  (
    .clk(clk),
    .rst(rst),
    .flitIn(flitIn),
    .req(req),
    .grant(grant),
    .flitOut(flitOut),
    .flitOutValid(flitOutValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==============================
  // stimulus helpers
  // ==============================

  // galois lfsr stepped once per bit taken.
  task automatic drawBits(input int n, output logic [routerPkg::flitWidth-1:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
  endtask

  function automatic logic [routerPkg::flitWidth-1:0] headFlit(input int len);
    headFlit = '0;
    headFlit[routerPkg::flitWidth-1 -: routerPkg::flitIdWidth] = routerPkg::flitHead;
    headFlit[routerPkg::lengthWidth-1:0] = len[routerPkg::lengthWidth-1:0];
  endfunction

  function automatic logic [routerPkg::flitWidth-1:0] codedFlit(
    input logic [routerPkg::flitIdWidth-1:0] code
  );
    codedFlit = '0;
    codedFlit[routerPkg::flitWidth-1 -: routerPkg::flitIdWidth] = code;
  endfunction

  // every word that is not a head flit gets a random payload.
  task automatic addRow(
    input int testId,
    input logic [routerPkg::portCount-1:0] r,
    input logic [routerPkg::flitWidth-1:0] fLocal,
    input logic [routerPkg::flitWidth-1:0] fNorth,
    input logic [routerPkg::flitWidth-1:0] fEast,
    input logic [routerPkg::flitWidth-1:0] fWest,
    input logic [routerPkg::flitWidth-1:0] fSouth
  );
    stimRow row;
    logic [routerPkg::flitWidth-1:0] bits;
    row.testId = testId;
    row.req = r;
    row.flit[0] = fLocal;
    row.flit[1] = fNorth;
    row.flit[2] = fEast;
    row.flit[3] = fWest;
    row.flit[4] = fSouth;
    for (int ch = 0; ch < routerPkg::portCount; ch++)
    begin
      if (row.flit[ch][routerPkg::flitWidth-1 -: routerPkg::flitIdWidth] != routerPkg::flitHead)
      begin
        drawBits(payloadWidth, bits);
        row.flit[ch][payloadWidth-1:0] = bits[payloadWidth-1:0];
      end
    end
    rows.push_back(row);
  endtask

  task automatic buildTable();
    logic [routerPkg::flitWidth-1:0] none;
    logic [routerPkg::flitWidth-1:0] body;
    logic [routerPkg::flitWidth-1:0] tail;
    logic [routerPkg::flitWidth-1:0] bad;
    none = codedFlit(routerPkg::flitNone);
    body = codedFlit(routerPkg::flitBody);
    tail = codedFlit(routerPkg::flitTail);
    bad = codedFlit(3'b011);  // undefined type code.
    testName[1] = "idle after reset";
    testName[2] = "fixed priority from idle";
    testName[3] = "round robin on release";
    testName[4] = "grant timer length";
    testName[5] = "flit pass-through";
    repeat (3) addRow(1, 5'b00000, none, none, none, none, none);
    addRow(2, 5'b00111, headFlit(1), headFlit(1), headFlit(1), none, none);
    repeat (6) addRow(2, 5'b00111, body, body, body, none, none);
    repeat (2) addRow(2, 5'b00000, none, none, none, none, none);
    addRow(3, 5'b11000, none, none, none, headFlit(10), headFlit(10));
    addRow(3, 5'b11000, none, none, none, body, body);
    addRow(3, 5'b10001, headFlit(10), none, none, body, body);  // west lets go.
    addRow(3, 5'b10001, body, none, none, none, body);
    repeat (2) addRow(3, 5'b00001, body, none, none, none, body);  // south wraps to local.
    repeat (2) addRow(3, 5'b00000, none, none, none, none, none);
    addRow(4, 5'b00100, none, none, headFlit(3), none, none);
    repeat (8) addRow(4, 5'b00100, none, none, body, none, none);
    repeat (2) addRow(4, 5'b00000, none, none, none, none, none);
    addRow(4, 5'b00110, none, headFlit(2), headFlit(0), none, none);
    repeat (7) addRow(4, 5'b00110, none, body, body, none, none);
    repeat (2) addRow(4, 5'b00000, none, none, none, none, none);
    addRow(5, 5'b10000, body, bad, none, none, headFlit(5));
    repeat (3) addRow(5, 5'b10000, body, bad, none, none, body);
    addRow(5, 5'b00000, body, bad, none, none, body);
    repeat (6) addRow(5, 5'b10000, body, bad, body, none, body);
    addRow(5, 5'b10000, body, bad, none, none, tail);
    // north keeps the length of its last head flit while it sends undefined codes.
    repeat (4) addRow(5, 5'b00010, none, bad, none, none, none);
    repeat (2) addRow(5, 5'b00000, none, none, none, none, none);
  endtask

  // ==============================
  // reference model
  // ==============================

  // one clock edge with the inputs that were present before it.
  task automatic modelStep(
    input logic [routerPkg::portCount-1:0] r,
    input logic [routerPkg::portCount-1:0][routerPkg::flitWidth-1:0] f
  );
    int nextHolder;
    int cand;
    logic [routerPkg::portCount-1:0] run;
    logic [routerPkg::portCount-1:0] expired;
    nextHolder = -1;
    run = '0;
    for (int ch = 0; ch < routerPkg::portCount; ch++)
    begin
      expired[ch] = (mCount[ch] == mLimit[ch]);
    end
    if (mHolder < 0)
    begin
      for (int ch = routerPkg::portCount - 1; ch >= 0; ch--)
      begin
        if (r[ch])
          nextHolder = ch;  // lowest index wins.
      end
    end
    else if (r[mHolder] && !expired[mHolder])
    begin
      run[mHolder] = 1'b1;
      nextHolder = mHolder;
    end
    else
    begin
      for (int k = routerPkg::portCount - 1; k >= 1; k--)
      begin
        cand = (mHolder + k) % routerPkg::portCount;
        if (r[cand])
          nextHolder = cand;
      end
    end
    mFlitOut = (mHolder >= 0) ? f[mHolder] : '0;
    mValidOut = (mHolder >= 0) ? r[mHolder] : 1'b0;
    for (int ch = 0; ch < routerPkg::portCount; ch++)
    begin
      if (f[ch][routerPkg::flitWidth-1 -: routerPkg::flitIdWidth] == routerPkg::flitHead)
        mLimit[ch] = int'(f[ch][routerPkg::lengthWidth-1:0]);
      mCount[ch] = run[ch] ? mCount[ch] + 1 : 0;
    end
    mHolder = nextHolder;
  endtask

  // ==============================
  // checks and reporting
  // ==============================

  task automatic noteError(input int testId);
    errCount++;
    testErrors[testId]++;
  endtask

  task automatic checkOutputs(input int testId);
    logic [routerPkg::portCount-1:0] expGrant;
    expGrant = '0;
    if (mHolder >= 0)
      expGrant[mHolder] = 1'b1;
    checkCount += 3;
    assert (grant === expGrant)
    else
    begin
      $display("MISMATCH time=%0t signal=grant expected=%b actual=%b",
        $time, expGrant, grant);
      noteError(testId);
    end
    assert (flitOut === mFlitOut)
    else
    begin
      $display("MISMATCH time=%0t signal=flitOut expected=%h actual=%h",
        $time, mFlitOut, flitOut);
      noteError(testId);
    end
    assert (flitOutValid === mValidOut)
    else
    begin
      $display("MISMATCH time=%0t signal=flitOutValid expected=%b actual=%b",
        $time, mValidOut, flitOutValid);
      noteError(testId);
    end
  endtask

  task automatic reportTest(input int testId);
    $display("test %0d, %s: %0d errors", testId, testName[testId], testErrors[testId]);
  endtask

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout: the run did not end within %0d cycles", cycleLimit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    rst = 1'b1;
    req = '0;
    flitIn = '0;
    lfsr = 32'h3623;
    errCount = 0;
    checkCount = 0;
    cycleCount = 0;
    mHolder = -1;
    mFlitOut = '0;
    mValidOut = 1'b0;
    appliedReq = '0;
    appliedFlit = '0;
    for (int ch = 0; ch < routerPkg::portCount; ch++)
    begin
      mLimit[ch] = 0;
      mCount[ch] = 0;
    end
    for (int t = 1; t <= testCount; t++)
    begin
      testErrors[t] = 0;
    end
    buildTable();
    cycleLimit = rows.size() + resetCycles + drainCycles + 20;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < rows.size(); i++)
    begin
      if (i > 0 && rows[i].testId != rows[i-1].testId)
        reportTest(rows[i-1].testId);
      @(posedge clk);
      modelStep(appliedReq, appliedFlit);
      req <= rows[i].req;
      flitIn <= rows[i].flit;
      appliedReq = rows[i].req;
      appliedFlit = rows[i].flit;
      @(negedge clk);
      checkOutputs(rows[i].testId);
    end
    // let the last inputs work through both pipeline stages.
    repeat (drainCycles)
    begin
      @(posedge clk);
      modelStep(appliedReq, appliedFlit);
      req <= '0;
      flitIn <= '0;
      appliedReq = '0;
      appliedFlit = '0;
      @(negedge clk);
      checkOutputs(rows[rows.size()-1].testId);
    end
    reportTest(rows[rows.size()-1].testId);
    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/flitDecoder.sv
`default_nettype none

module flitDecoder
(
  input  logic [routerPkg::portCount-1:0][routerPkg::flitWidth-1:0] flitIn,
  output routerPkg::flitType [routerPkg::portCount-1:0] flitId,
  output logic [routerPkg::portCount-1:0][routerPkg::lengthWidth-1:0] length
);

  genvar ch;

  generate
    for (ch = 0; ch < routerPkg::portCount; ch++)
    begin : gChannel
      logic [routerPkg::flitIdWidth-1:0] code;

      assign code = flitIn[ch][routerPkg::flitWidth-1 -: routerPkg::flitIdWidth];

      // unknown codes are treated as an empty slot.
      always_comb
      begin
        case (code)
          routerPkg::flitHead:
            flitId[ch] = routerPkg::flitHead;
          routerPkg::flitBody:
            flitId[ch] = routerPkg::flitBody;
          routerPkg::flitTail:
            flitId[ch] = routerPkg::flitTail;
          default:
            flitId[ch] = routerPkg::flitNone;
        endcase
      end

      // only a head flit carries a length, body payload must not reach the timers.
      always_comb
      begin
        if (flitId[ch] == routerPkg::flitHead)
          length[ch] = flitIn[ch][routerPkg::lengthWidth-1:0];
        else
          length[ch] = '0;
      end
    end
  endgenerate

endmodule

`default_nettype wire

// File: design/flitSwitch.sv
`default_nettype none

module flitSwitch
(
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::portCount-1:0][routerPkg::flitWidth-1:0] flitIn,
  input  logic [routerPkg::portCount-1:0] req,
  input  logic [routerPkg::portCount-1:0] grant,
  output logic [routerPkg::flitWidth-1:0] flitOut,
  output logic flitOutValid
);

  logic [routerPkg::flitWidth-1:0] selFlit;
  logic selValid;

  // and-or mux, grant is at most one-hot so no priority is needed.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < routerPkg::portCount; i++)
    begin
      selFlit = selFlit | (flitIn[i] & {routerPkg::flitWidth{grant[i]}});
    end
  end

  assign selValid = |(grant & req);  // low when idle or the holder stopped requesting.

  // ==============================
  // output register
  // ==============================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitOut <= '0;
      flitOutValid <= 1'b0;
    end
    else
    begin
      flitOut <= selFlit;
      flitOutValid <= selValid;
    end
  end

  // grant comes from the arbiter state, two owners would corrupt the output.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("flitSwitch grant %b has more than one bit set", grant);

endmodule

`default_nettype wire

// File: design/grantTimer.sv
`default_nettype none

module grantTimer
(
  input  logic clk,
  input  logic rst,
  input  routerPkg::flitType flitId,
  input  logic [routerPkg::lengthWidth-1:0] length,
  input  logic run,
  output logic expired
);

  logic [routerPkg::lengthWidth-1:0] limit;  // length of the last head flit seen.
  logic [routerPkg::lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == routerPkg::flitHead)
        limit <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;  // any cycle off the output restarts the budget.
    end
  end

  // a zero length expires in the very first cycle of a grant.
  assign expired = (count == limit);

  // the arbiter must drop run once the count reaches the limit.
  countWithinLimit: assert property (@(posedge clk) disable iff (rst)
    run |-> (count <= limit))
    else $error("grantTimer count %0d passed limit %0d", count, limit);

endmodule

`default_nettype wire

// File: design/portArbiter.sv
`default_nettype none

module portArbiter
(
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::portCount-1:0] req,
  input  routerPkg::flitType [routerPkg::portCount-1:0] flitId,
  input  logic [routerPkg::portCount-1:0][routerPkg::lengthWidth-1:0] length,
  output logic [routerPkg::portCount-1:0] grant
);

  routerPkg::arbState state;
  routerPkg::arbState nextState;
  logic [routerPkg::portCount-1:0] run;
  logic [routerPkg::portCount-1:0] expired;
  logic [routerPkg::portCount-1:0] others;  // requests without the current holder.

  // first requester found when scanning from channel start upwards with wrap.
  function automatic routerPkg::arbState pickNext(
    input logic [routerPkg::portCount-1:0] reqs,
    input int start
  );
    logic [routerPkg::portCount:0] oneHot;
    int idx;
    oneHot = routerPkg::stIdle;
    for (int k = routerPkg::portCount - 1; k >= 0; k--)
    begin
      idx = (start + k) % routerPkg::portCount;
      if (reqs[idx])
      begin
        oneHot = '0;
        oneHot[idx + 1] = 1'b1;
      end
    end
    return routerPkg::arbState'(oneHot);
  endfunction

  // ==============================
  // grant timers
  // ==============================

  genvar ch;

  generate
    for (ch = 0; ch < routerPkg::portCount; ch++)
    begin : gTimer
      grantTimer timer0
      (
        .clk(clk),
        .rst(rst),
        .flitId(flitId[ch]),
        .length(length[ch]),
        .run(run[ch]),
        .expired(expired[ch])
      );
    end
  endgenerate

  // ==============================
  // state machine
  // ==============================

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= routerPkg::stIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    run = '0;
    others = '0;
    nextState = routerPkg::stIdle;
    case (state)
      routerPkg::stIdle:
        nextState = pickNext(req, 0);  // fixed priority, local first.
      routerPkg::stLocal, routerPkg::stNorth, routerPkg::stEast,
      routerPkg::stWest, routerPkg::stSouth:
      begin
        for (int h = 0; h < routerPkg::portCount; h++)
        begin
          if (state[h + 1])
          begin
            if (req[h] && !expired[h])
            begin
              run[h] = 1'b1;
              nextState = state;
            end
            else
            begin
              others = req;
              others[h] = 1'b0;
              nextState = pickNext(others, h + 1);  // round robin after the holder.
            end
          end
        end
      end
      default:
        nextState = routerPkg::stIdle;
    endcase
  end

  assign grant = state[routerPkg::portCount:1];

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("portArbiter state %b is not one-hot", state);

endmodule

`default_nettype wire

// File: design/routerOutput.sv
`default_nettype none

module routerOutput
(
  input  logic clk,
  input  logic rst,
  input  logic [routerPkg::portCount-1:0][routerPkg::flitWidth-1:0] flitIn,
  input  logic [routerPkg::portCount-1:0] req,
  output logic [routerPkg::portCount-1:0] grant,
  output logic [routerPkg::flitWidth-1:0] flitOut,
  output logic flitOutValid
);

  routerPkg::flitType [routerPkg::portCount-1:0] flitId;
  logic [routerPkg::portCount-1:0][routerPkg::lengthWidth-1:0] length;

  // decode stage.
  flitDecoder decoder0
  (
    .flitIn(flitIn),
    .flitId(flitId),
    .length(length)
  );

  // execute stage, one cycle from request to grant.
  portArbiter arbiter0
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .flitId(flitId),
    .length(length),
    .grant(grant)
  );

  // result stage, one more cycle to the output.
  flitSwitch switch0
  (
    .clk(clk),
    .rst(rst),
    .flitIn(flitIn),
    .req(req),
    .grant(grant),
    .flitOut(flitOut),
    .flitOutValid(flitOutValid)
  );

endmodule

`default_nettype wire

// File: design/routerPkg.sv
`default_nettype none

package routerPkg;

  // ==============================
  // sizes
  // ==============================

  localparam int portCount = 5;     // local, north, east, west, south.
  localparam int flitWidth = 16;
  localparam int lengthWidth = 12;  // head flits carry the packet length in the low bits.
  localparam int flitIdWidth = 3;   // type code sits in the top bits of every flit.

  // ==============================
  // types
  // ==============================

  typedef enum logic [flitIdWidth-1:0] {
    flitNone = 3'b000,
    flitHead = 3'b001,
    flitBody = 3'b010,
    flitTail = 3'b100
  } flitType;

  // one-hot arbiter state with idle in the lowest bit.
  // bit i+1 is set while channel i holds the output.
  typedef enum logic [portCount:0] {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbState;

endpackage

`default_nettype wire

// File: project.f
design/routerPkg.sv
design/flitDecoder.sv
design/grantTimer.sv
design/portArbiter.sv
design/flitSwitch.sv
design/routerOutput.sv
bench/routerOutputTb.sv
